//--- project.f
+incdir+rtl
rtl/core_pkg.sv
rtl/decoder.sv
rtl/immGen.sv
rtl/regFile.sv
rtl/execUnit.sv
rtl/fetchPc.sv
rtl/rvCore.sv
sim/rvCore_tb.sv

//--- rtl/core_defs.svh
`ifndef CORE_DEFS_SVH
`define CORE_DEFS_SVH

// one machine word, data and address
`define CORE_XLEN 64

// architectural integer registers, x0 included
`define CORE_NUM_REGS 32

// first fetch address after reset
`define CORE_RESET_PC 64'h8000_0000

`endif

//--- rtl/core_pkg.sv
`default_nettype none

`include "core_defs.svh"

package core_pkg;

    typedef logic [`CORE_XLEN-1:0] word_t;
    typedef logic [31:0] inst_t;
    typedef logic [4:0] regAddr_t;
    typedef logic [7:0] byteMask_t;
    typedef logic [6:0] opcode_t;
    typedef logic [2:0] funct3_t;
    typedef logic [6:0] funct7_t;

    // major opcodes of the supported subset
    localparam opcode_t opOp = 7'b0110011;
    localparam opcode_t opImm = 7'b0010011;
    localparam opcode_t opAuipc = 7'b0010111;
    localparam opcode_t opLui = 7'b0110111;
    localparam opcode_t opJal = 7'b1101111;
    localparam opcode_t opStore = 7'b0100011;
    localparam opcode_t opSystem = 7'b1110011;

    localparam inst_t instEbreak = 32'h0010_0073;

    typedef enum logic {
        aluAdd,
        aluPassB
    } aluOp_e;

    typedef enum logic {
        wbAlu,
        wbPcPlus4
    } wbSel_e;

    typedef enum logic {
        stRun,
        stHalt
    } runState_e;

    typedef struct packed {
        aluOp_e aluOperate;
        logic selA; // 1 rs1, 0 pc
        logic selB; // 1 rs2, 0 imm
        logic writeRd;
        logic npcJump; // next pc is pc + imm
        byteMask_t memoryWriteMask;
        wbSel_e writeBackSelect;
        logic isEbreak;
    } decodeCtrl_t;

    typedef struct packed {
        byteMask_t mask;
        word_t address;
        word_t data; // rs2, not lane shifted
    } storeReq_t;

endpackage

`default_nettype wire

//--- rtl/decoder.sv
`timescale 1ns/1ps
`default_nettype none

module decoder
    import core_pkg::*;
(
    input inst_t inst,
    output decodeCtrl_t ctrl
);

    // every field inactive, acts as a no-op
    localparam decodeCtrl_t ctrlNop = '{
        aluOperate: aluAdd,
        selA: 1'b0,
        selB: 1'b0,
        writeRd: 1'b0,
        npcJump: 1'b0,
        memoryWriteMask: '0,
        writeBackSelect: wbAlu,
        isEbreak: 1'b0
    };

    opcode_t opcode;
    funct3_t funct3;
    funct7_t funct7;

    assign opcode = inst[6:0];
    assign funct3 = inst[14:12];
    assign funct7 = inst[31:25];

    always_comb
    begin
        ctrl = ctrlNop;
        case (opcode)
            opOp:
            begin
                if (funct3 == 3'b000 && funct7 == 7'b0000000) // add
                begin
                    ctrl.aluOperate = aluAdd;
                    ctrl.selA = 1'b1;
                    ctrl.selB = 1'b1;
                    ctrl.writeRd = 1'b1;
                end
            end
            opImm:
            begin
                if (funct3 == 3'b000) // addi
                begin
                    ctrl.aluOperate = aluAdd;
                    ctrl.selA = 1'b1;
                    ctrl.selB = 1'b0;
                    ctrl.writeRd = 1'b1;
                end
            end
            opAuipc:
            begin
                ctrl.aluOperate = aluAdd; // pc + imm
                ctrl.selA = 1'b0;
                ctrl.selB = 1'b0;
                ctrl.writeRd = 1'b1;
            end
            opLui:
            begin
                ctrl.aluOperate = aluPassB;
                ctrl.selB = 1'b0;
                ctrl.writeRd = 1'b1;
            end
            opJal:
            begin
                ctrl.writeRd = 1'b1;
                ctrl.npcJump = 1'b1;
                ctrl.writeBackSelect = wbPcPlus4;
            end
            opStore:
            begin
                // address is always rs1 + imm
                ctrl.aluOperate = aluAdd;
                ctrl.selA = 1'b1;
                ctrl.selB = 1'b0;
                case (funct3)
                    3'b000: ctrl.memoryWriteMask = 8'b0000_0001; // sb
                    3'b001: ctrl.memoryWriteMask = 8'b0000_0011; // sh
                    3'b010: ctrl.memoryWriteMask = 8'b0000_1111; // sw
                    3'b011: ctrl.memoryWriteMask = 8'b1111_1111; // sd
                    default: ctrl.memoryWriteMask = '0;
                endcase
            end
            opSystem:
            begin
                ctrl.isEbreak = (inst == instEbreak);
            end
            default:
            begin
                ctrl = ctrlNop;
            end
        endcase
    end

    noStoreWrite: assert final (ctrl.memoryWriteMask == '0 || !ctrl.writeRd)
        else $error("decoder: store with register write, inst %h", inst);

endmodule

`default_nettype wire

//--- rtl/execUnit.sv
`timescale 1ns/1ps
`default_nettype none

module execUnit
    import core_pkg::*;
(
    input decodeCtrl_t ctrl,
    input word_t pc,
    input word_t imm,
    input word_t rs1Data,
    input word_t rs2Data,
    output word_t rdData,
    output logic rdWrite,
    output word_t jumpTarget,
    output storeReq_t storeReq,
    input wire halted
);

    word_t operandA;
    word_t operandB;
    word_t aluResult;
    word_t pcPlus4;

    assign operandA = ctrl.selA ? rs1Data : pc;
    assign operandB = ctrl.selB ? rs2Data : imm;
    assign pcPlus4 = pc + word_t'(4);

    always_comb
    begin
        case (ctrl.aluOperate)
            aluAdd: aluResult = operandA + operandB;
            aluPassB: aluResult = operandB; // lui
            default: aluResult = operandB;
        endcase
    end

    always_comb
    begin
        case (ctrl.writeBackSelect)
            wbPcPlus4: rdData = pcPlus4; // jal link
            default: rdData = aluResult;
        endcase
    end

    assign jumpTarget = pc + imm;

    // a halted core neither writes registers nor stores
    assign rdWrite = ctrl.writeRd && !halted;

    assign storeReq = '{
        mask: halted ? '0 : ctrl.memoryWriteMask,
        address: aluResult,
        data: rs2Data
    };

endmodule

`default_nettype wire

//--- rtl/fetchPc.sv
`timescale 1ns/1ps
`default_nettype none

`include "core_defs.svh"

module fetchPc
    import core_pkg::*;
(
    input wire clock,
    input wire reset,
    input wire npcJump,
    input word_t jumpTarget,
    input wire ebreak,
    output word_t pc,
    output logic halted
);

    runState_e state;

    always_ff @(posedge clock)
    begin
        if (reset)
        begin
            state <= stRun;
            pc <= `CORE_RESET_PC;
        end
        else
        begin
            case (state)
                stRun:
                begin
                    if (ebreak)
                    begin
                        state <= stHalt; // pc stays on the ebreak
                    end
                    else if (npcJump)
                    begin
                        pc <= jumpTarget;
                    end
                    else
                    begin
                        pc <= pc + word_t'(4);
                    end
                end
                default:
                begin
                    state <= stHalt;
                end
            endcase
        end
    end

    assign halted = (state == stHalt);

    pcFrozen: assert property (@(posedge clock) disable iff (reset)
        (state == stHalt && !reset) |=> $stable(pc))
        else $error("fetchPc: pc moved while halted");

endmodule

`default_nettype wire

//--- rtl/immGen.sv
`timescale 1ns/1ps
`default_nettype none

`include "core_defs.svh"

module immGen
    import core_pkg::*;
(
    input inst_t inst,
    output word_t imm
);

    opcode_t opcode;
    logic signBit;

    assign opcode = inst[6:0];
    assign signBit = inst[31];

    always_comb
    begin
        case (opcode)
            opStore: // S format
            begin
                imm = {{(`CORE_XLEN-12){signBit}}, inst[31:25], inst[11:7]};
            end
            opAuipc, opLui: // U format
            begin
                imm = {{(`CORE_XLEN-32){signBit}}, inst[31:12], 12'b0};
            end
            opJal: // J format, bit 0 always zero
            begin
                imm = {{(`CORE_XLEN-20){signBit}}, inst[19:12], inst[20],
                    inst[30:21], 1'b0};
            end
            default: // I format
            begin
                imm = {{(`CORE_XLEN-12){signBit}}, inst[31:20]};
            end
        endcase
    end

endmodule

`default_nettype wire

//--- rtl/regFile.sv
`timescale 1ns/1ps
`default_nettype none

`include "core_defs.svh"

module regFile
    import core_pkg::*;
(
    input wire clock,
    input wire reset,
    input regAddr_t rs1Addr,
    input regAddr_t rs2Addr,
    output word_t rs1Data,
    output word_t rs2Data,
    input regAddr_t rdAddr,
    input word_t rdData,
    input wire rdWrite
);

    word_t regs [`CORE_NUM_REGS];

    always_ff @(posedge clock)
    begin
        if (reset)
        begin
            for (int i = 0; i < `CORE_NUM_REGS; i++)
            begin
                regs[i] <= '0;
            end
        end
        else if (rdWrite && rdAddr != '0) // x0 writes dropped
        begin
            regs[rdAddr] <= rdData;
        end
    end

    assign rs1Data = (rs1Addr == '0) ? '0 : regs[rs1Addr];
    assign rs2Data = (rs2Addr == '0) ? '0 : regs[rs2Addr];

endmodule

`default_nettype wire

//--- rtl/rvCore.sv
`timescale 1ns/1ps
`default_nettype none

module rvCore
    import core_pkg::*;
(
    input wire clock,
    input wire reset,
    output word_t pc,
    input inst_t inst,
    output storeReq_t storeReq,
    output logic halted
);

    decodeCtrl_t ctrl;
    word_t imm;
    word_t rs1Data;
    word_t rs2Data;
    word_t rdData;
    logic rdWrite;
    word_t jumpTarget;
    storeReq_t execStore;

    fetchPc i_fetchPc (
        .clock(clock),
        .reset(reset),
        .npcJump(ctrl.npcJump),
        .jumpTarget(jumpTarget),
        .ebreak(ctrl.isEbreak),
        .pc(pc),
        .halted(halted)
    );

    decoder i_decoder (
        .inst(inst),
        .ctrl(ctrl)
    );

    immGen i_immGen (
        .inst(inst),
        .imm(imm)
    );

    regFile i_regFile (
        .clock(clock),
        .reset(reset),
        .rs1Addr(inst[19:15]),
        .rs2Addr(inst[24:20]),
        .rs1Data(rs1Data),
        .rs2Data(rs2Data),
        .rdAddr(inst[11:7]),
        .rdData(rdData),
        .rdWrite(rdWrite && !reset) // no writes during reset
    );

    execUnit i_execUnit (
        .ctrl(ctrl),
        .pc(pc),
        .imm(imm),
        .rs1Data(rs1Data),
        .rs2Data(rs2Data),
        .rdData(rdData),
        .rdWrite(rdWrite),
        .jumpTarget(jumpTarget),
        .storeReq(execStore),
        .halted(halted)
    );

    assign storeReq = '{
        mask: reset ? '0 : execStore.mask,
        address: execStore.address,
        data: execStore.data
    };

    // halt state in fetchPc must silence the store port in execUnit
    haltNoStore: assert property (@(posedge clock) disable iff (reset)
        halted |-> storeReq.mask == '0)
        else $error("rvCore: store issued while halted");

endmodule

`default_nettype wire

//--- sim/rvCore_tb.sv
`timescale 1ns/1ps
`default_nettype none

`include "core_defs.svh"

module rvCore_tb
    import core_pkg::*;
();

    localparam int cycleLimit = 2000;
    localparam inst_t nopInst = 32'h0000_0013; // addi x0, x0, 0

    logic clock;
    logic reset;
    inst_t inst;
    word_t pc;
    storeReq_t storeReq;
    logic halted;

    inst_t rom [word_t]; // behavioral instruction memory
    word_t expPc [$];
    storeReq_t expStore [$];
    word_t model [`CORE_NUM_REGS]; // reference register values
    word_t buildPc;
    int errors = 0;
    int checks = 0;
    int cycleCount = 0;

    rvCore i_rvCore (
        .clock(clock),
        .reset(reset),
        .pc(pc),
        .inst(inst),
        .storeReq(storeReq),
        .halted(halted)
    );

    initial
    begin
        clock = 1'b0;
        forever #4 clock = ~clock;
    end

    initial
    begin
        while (cycleCount < cycleLimit)
        begin
            @(posedge clock);
            cycleCount++;
        end
        $display("timeout after %0d cycles, the tests did not finish", cycleLimit);
        $display("Simulation FAILED");
        $finish;
    end

    task automatic checkStore(input string name, input storeReq_t exp, input storeReq_t act);
        checks++;
        // address and data only matter when a store is expected
        if (exp.mask == '0 ? act.mask !== '0 : act !== exp)
        begin
            errors++;
            $display(
                "ERROR %s store: expected mask %h addr %h data %h, actual mask %h addr %h data %h",
                name, exp.mask, exp.address, exp.data, act.mask, act.address, act.data);
        end
    endtask

    task automatic checkWord(input string name, input word_t exp, input word_t act);
        checks++;
        if (act !== exp)
        begin
            errors++;
            $display("ERROR %s pc: expected %h, actual %h", name, exp, act);
        end
    endtask

    task automatic checkFlag(input string name, input logic exp, input logic act);
        checks++;
        if (act !== exp)
        begin
            errors++;
            $display("ERROR %s halted: expected %b, actual %b", name, exp, act);
        end
    endtask

    function automatic word_t sext12(input logic [11:0] v);
        return {{(`CORE_XLEN-12){v[11]}}, v};
    endfunction

    function automatic word_t upperImm(input logic [19:0] v);
        return {{(`CORE_XLEN-32){v[19]}}, v, 12'b0};
    endfunction

    function automatic storeReq_t noStore();
        return '{mask: '0, address: '0, data: '0};
    endfunction

    function automatic inst_t encStore(input logic [2:0] f3, input regAddr_t rs1,
        input regAddr_t rs2, input logic [11:0] imm);
        return {imm[11:5], rs2, rs1, f3, imm[4:0], opStore};
    endfunction

    task automatic newProgram();
        rom.delete();
        expPc.delete();
        expStore.delete();
        buildPc = `CORE_RESET_PC;
        for (int i = 0; i < `CORE_NUM_REGS; i++)
        begin
            model[i] = '0;
        end
    endtask

    task automatic emit(input inst_t i, input storeReq_t s);
        rom[buildPc] = i;
        expPc.push_back(buildPc);
        expStore.push_back(s);
        buildPc += 4;
    endtask

    task automatic setReg(input regAddr_t rd, input word_t v);
        if (rd != '0) // x0 stays zero
        begin
            model[rd] = v;
        end
    endtask

    task automatic doLui(input regAddr_t rd, input logic [19:0] imm);
        emit({imm, rd, opLui}, noStore());
        setReg(rd, upperImm(imm));
    endtask

    task automatic doAuipc(input regAddr_t rd, input logic [19:0] imm);
        word_t result;
        result = buildPc + upperImm(imm);
        emit({imm, rd, opAuipc}, noStore());
        setReg(rd, result);
    endtask

    task automatic doAddi(input regAddr_t rd, input regAddr_t rs1, input logic [11:0] imm);
        emit({imm, rs1, 3'b000, rd, opImm}, noStore());
        setReg(rd, model[rs1] + sext12(imm));
    endtask

    task automatic doAdd(input regAddr_t rd, input regAddr_t rs1, input regAddr_t rs2);
        emit({7'b0, rs2, rs1, 3'b000, rd, opOp}, noStore());
        setReg(rd, model[rs1] + model[rs2]);
    endtask

    task automatic doJal(input regAddr_t rd, input logic [20:0] off);
        word_t here;
        here = buildPc;
        emit({off[20], off[10:1], off[11], off[19:12], rd, opJal}, noStore());
        setReg(rd, here + 4);
        buildPc = here + {{(`CORE_XLEN-21){off[20]}}, off};
    endtask

    task automatic doStore(input logic [2:0] f3, input regAddr_t rs1, input regAddr_t rs2,
        input logic [11:0] imm);
        storeReq_t s;
        case (f3)
            3'd0: s.mask = 8'h01; // sb
            3'd1: s.mask = 8'h03;
            3'd2: s.mask = 8'h0f;
            default: s.mask = 8'hff; // sd
        endcase
        s.address = model[rs1] + sext12(imm);
        s.data = model[rs2];
        emit(encStore(f3, rs1, rs2, imm), s);
    endtask

    task automatic driveInst();
        inst = rom.exists(pc) ? rom[pc] : nopInst; // unloaded address reads as no-op
    endtask

    task automatic resetCore();
        @(negedge clock);
        reset = 1'b1;
        repeat (10)
        begin
            @(negedge clock);
            driveInst();
        end
        reset = 1'b0;
    endtask

    // leaves the clock at the falling edge after the last instruction executed
    task automatic runProgram(input string name);
        resetCore();
        for (int k = 0; k < expPc.size(); k++)
        begin
            #1;
            checkWord(name, expPc[k], pc);
            checkStore(name, expStore[k], storeReq);
            checkFlag(name, 1'b0, halted);
            @(negedge clock);
            driveInst();
        end
    endtask

    task automatic testArith();
        regAddr_t rd;
        newProgram();
        for (int i = 0; i < 16; i++)
        begin
            rd = regAddr_t'($urandom_range(7, 1));
            case ($urandom_range(2, 0))
                0: doLui(rd, 20'($urandom));
                1: doAddi(rd, regAddr_t'($urandom_range(7, 0)), 12'($urandom));
                default: doAdd(rd, regAddr_t'($urandom_range(7, 0)),
                    regAddr_t'($urandom_range(7, 0)));
            endcase
        end
        for (int r = 1; r < 8; r++)
        begin
            doStore(3'd3, regAddr_t'($urandom_range(7, 0)), regAddr_t'(r), 12'($urandom));
        end
        runProgram("arith");
    endtask

    task automatic testStoreWidths();
        newProgram();
        doLui(5'd1, 20'($urandom));
        doAddi(5'd1, 5'd1, 12'($urandom));
        doLui(5'd2, 20'h00012);
        for (int f = 0; f < 4; f++)
        begin
            doStore(3'(f), 5'd2, 5'd1, 12'(8 * f));
            doAddi(5'd3, 5'd3, 12'd1); // zero mask between stores
        end
        runProgram("storeWidths");
    endtask

    task automatic testAuipcJal();
        newProgram();
        doAuipc(5'd3, 20'($urandom));
        doStore(3'd3, 5'd0, 5'd3, 12'h008);
        doJal(5'd4, 21'd16);
        doStore(3'd3, 5'd0, 5'd4, 12'h010);
        doJal(5'd5, 21'h000100);
        doStore(3'd3, 5'd4, 5'd5, 12'hff8);
        doStore(3'd3, 5'd0, 5'd3, 12'h018);
        runProgram("auipcJal");
    endtask

    task automatic testX0Nop();
        newProgram();
        doAddi(5'd1, 5'd0, 12'h123);
        doAddi(5'd0, 5'd0, 12'h055);
        doLui(5'd0, 20'($urandom));
        doAdd(5'd0, 5'd1, 5'd1);
        doStore(3'd3, 5'd1, 5'd0, 12'h000);
        emit({20'h12345, 5'd1, 7'b1111111}, noStore()); // unknown opcode aimed at x1
        doStore(3'd3, 5'd0, 5'd1, 12'h020);
        runProgram("x0Nop");
    endtask

    task automatic testEbreak();
        word_t stopPc;
        inst_t haltInst;
        newProgram();
        doLui(5'd5, 20'($urandom));
        doStore(3'd3, 5'd0, 5'd5, 12'h040);
        emit(instEbreak, noStore());
        stopPc = expPc[$];
        haltInst = encStore(3'd3, 5'd0, 5'd5, 12'h048);
        runProgram("ebreak");
        repeat (20)
        begin
            inst = haltInst; // a live store would issue and move pc
            #1;
            checkFlag("ebreak", 1'b1, halted);
            checkWord("ebreak", stopPc, pc);
            checkStore("ebreak", noStore(), storeReq);
            @(negedge clock);
        end
    endtask

    task automatic testResetMid();
        newProgram();
        doAddi(5'd1, 5'd0, 12'($urandom));
        doAddi(5'd2, 5'd1, 12'($urandom));
        doAdd(5'd3, 5'd1, 5'd2);
        doStore(3'd3, 5'd1, 5'd3, 12'h000);
        emit(instEbreak, noStore());
        runProgram("resetMid");
        #1;
        checkFlag("resetMid", 1'b1, halted);
        resetCore();
        #1;
        checkWord("resetMid", `CORE_RESET_PC, pc);
        checkFlag("resetMid", 1'b0, halted);
        repeat (2)
        begin
            @(negedge clock);
            driveInst();
        end
        resetCore(); // again while running
        #1;
        checkWord("resetMid", `CORE_RESET_PC, pc);
        checkFlag("resetMid", 1'b0, halted);
        runProgram("resetMid");
    endtask

    initial
    begin
        reset = 1'b1;
        inst = nopInst;
        void'($urandom(32'h77d2_273e));
        testArith();
        testStoreWidths();
        testAuipcJal();
        testX0Nop();
        testEbreak();
        testResetMid();
        $display("%0d checks, %0d errors", checks, errors);
        if (errors == 0)
        begin
            $display("Simulation PASSED");
        end
        else
        begin
            $display("Simulation FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire
